//--- fpu_pkg.sv
package fpu_pkg;

	// IEEE 754 rounding direction
	typedef enum logic [2:0] {
		RM_RNE = 3'd0,	// Nearest, ties to even
		RM_RTZ = 3'd1,
		RM_RDN = 3'd2,
		RM_RUP = 3'd3,
		RM_RMM = 3'd4	// Nearest, ties away from zero
	} rm_t;

	// Exception flag bits
	localparam int FLAG_NV = 0;
	localparam int FLAG_NX = 1;

	// Register map, byte offsets
	localparam logic [7:0] REG_OPERAND = 8'h00;
	localparam logic [7:0] REG_CTRL    = 8'h04;
	localparam logic [7:0] REG_STATUS  = 8'h08;
	localparam logic [7:0] REG_RESULT  = 8'h0c;

	// Control word
	localparam int CTRL_START  = 0;
	localparam int CTRL_FLUSH  = 1;
	localparam int CTRL_RM_LSB = 2;	// Rounding mode in [4:2]

	// Status word
	localparam int STAT_BUSY      = 0;
	localparam int STAT_DONE      = 1;
	localparam int STAT_FLAGS_LSB = 2;	// Flags in [3:2]

endpackage

//--- float_pkg.sv
package float_pkg;

	// Significand including the hidden bit
	localparam int MAN_W  = 24;
	localparam int FRAC_W = 23;

	// Internal exponent is unbiased and signed
	localparam int EXP_W    = 10;
	localparam int EXP_BIAS = 127;

	localparam logic [7:0] EXP_ALL_ONES = 8'hff;

	// Canonical special values
	localparam logic [31:0] QNAN_BITS    = 32'h7fc0_0000;
	localparam logic [31:0] POS_INF_BITS = 32'h7f80_0000;

endpackage

//--- fpu_axil_regs.sv
`timescale 1ns/10ps

module fpu_axil_regs #(
	parameter int ADDR_W = 4
) (
	input	logic					clk,
	input	logic					reset,

	input	logic	[ADDR_W-1:0]	awaddr,
	input	logic					awvalid,
	output	logic					awready,
	input	logic	[31:0]			wdata,
	input	logic	[3:0]			wstrb,
	input	logic					wvalid,
	output	logic					wready,
	output	logic	[1:0]			bresp,
	output	logic					bvalid,
	input	logic					bready,
	input	logic	[ADDR_W-1:0]	araddr,
	input	logic					arvalid,
	output	logic					arready,
	output	logic	[31:0]			rdata,
	output	logic	[1:0]			rresp,
	output	logic					rvalid,
	input	logic					rready,

	output	logic					start_valid,
	input	logic					start_ready,
	output	logic	[31:0]			operand,
	output	fpu_pkg::rm_t			rm,
	output	logic					flush,
	input	logic					res_valid,
	input	logic	[31:0]			result,
	input	logic	[1:0]			flags
);
	import fpu_pkg::*;

	logic					wr_ack;
	logic					ar_ack;
	logic	[ADDR_W-1:0]	wr_word;
	logic	[ADDR_W-1:0]	rd_word;
	logic					ctrl_wr;
	logic					start_cmd;
	logic					flush_cmd;
	logic					res_take;
	logic					busy;
	logic					done;
	logic	[1:0]			flags_q;
	logic	[31:0]			result_q;
	logic	[31:0]			status;
	logic	[31:0]			rd_mux;

	assign awready = wr_ack;	// Address and data taken together
	assign wready  = wr_ack;
	assign arready = ar_ack;
	assign bresp   = 2'b00;
	assign rresp   = 2'b00;

	assign wr_word = {awaddr[ADDR_W-1:2], 2'b00};
	assign rd_word = {araddr[ADDR_W-1:2], 2'b00};

	assign ctrl_wr   = wr_ack && (wr_word == ADDR_W'(REG_CTRL));
	assign flush_cmd = ctrl_wr && wdata[CTRL_FLUSH];
	assign start_cmd = ctrl_wr && wdata[CTRL_START] && !wdata[CTRL_FLUSH] && !busy;
	assign res_take  = busy && res_valid && !flush_cmd;	// Stale results are dropped

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			wr_ack      <= 1'b0;
			bvalid      <= 1'b0;
			ar_ack      <= 1'b0;
			rvalid      <= 1'b0;
			flush       <= 1'b0;
			start_valid <= 1'b0;
			busy        <= 1'b0;
			done        <= 1'b0;
			flags_q     <= 2'b00;
			rm          <= RM_RNE;
		end else begin
			wr_ack <= awvalid && wvalid && !wr_ack && !bvalid;
			if (wr_ack)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;

			ar_ack <= arvalid && !ar_ack && !rvalid;
			if (ar_ack)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;

			flush <= flush_cmd;	// One cycle pulse to the chain

			if (flush_cmd) begin
				start_valid <= 1'b0;
				busy        <= 1'b0;
				done        <= 1'b0;
			end else if (start_cmd) begin
				start_valid <= 1'b1;
				busy        <= 1'b1;
				done        <= 1'b0;
				flags_q     <= 2'b00;
				rm          <= rm_t'(wdata[CTRL_RM_LSB +: 3]);
			end else begin
				if (start_valid && start_ready)
					start_valid <= 1'b0;
				if (res_take) begin
					busy    <= 1'b0;
					done    <= 1'b1;
					flags_q <= flags;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_ack && wr_word == ADDR_W'(REG_OPERAND)) begin
			for (int b = 0; b < 4; b++)
				if (wstrb[b])
					operand[8*b +: 8] <= wdata[8*b +: 8];
		end
		if (res_take)
			result_q <= result;
		if (ar_ack)
			rdata <= rd_mux;
	end

	always_comb begin
		status = '0;
		status[STAT_BUSY] = busy;
		status[STAT_DONE] = done;
		status[STAT_FLAGS_LSB +: 2] = flags_q;

		case (rd_word)
			ADDR_W'(REG_OPERAND):	rd_mux = operand;
			ADDR_W'(REG_CTRL):		rd_mux = {27'd0, rm, 2'b00};
			ADDR_W'(REG_STATUS):	rd_mux = status;
			ADDR_W'(REG_RESULT):	rd_mux = result_q;
			default:				rd_mux = 32'd0;
		endcase
	end

endmodule

//--- float_unpack.sv
`timescale 1ns/10ps

module float_unpack (
	input	logic								clk,
	input	logic								reset,
	input	logic								flush,

	input	logic								valid_in,
	output	logic								ready_out,
	input	logic	[31:0]						operand,
	input	fpu_pkg::rm_t						rm_in,

	output	logic								valid_out,
	input	logic								ready_in,
	output	logic	[float_pkg::MAN_W-1:0]		man_a,
	output	logic	signed [float_pkg::EXP_W-1:0]	exp_a,
	output	logic								sgn_a,
	output	logic								zero_a,
	output	logic								inf_a,
	output	logic								snan_a,
	output	logic								qnan_a,
	output	fpu_pkg::rm_t						rm_out
);
	import float_pkg::*;

	logic	[7:0]			exp_f;
	logic	[FRAC_W-1:0]	frac;
	logic	[4:0]			lz;
	logic	[MAN_W-1:0]		man_n;
	logic	[EXP_W-1:0]		exp_n;

	function automatic logic [4:0] lzc24(input logic [23:0] v);
		logic [4:0] n;
		n = 5'd24;
		for (int i = 0; i < 24; i++)
			if (v[i])
				n = 5'(23 - i);	// Highest set bit wins
		return n;
	endfunction

	assign exp_f     = operand[30:23];
	assign frac      = operand[FRAC_W-1:0];
	assign ready_out = !valid_out || ready_in;

	always_comb begin
		lz = lzc24({1'b0, frac});
		if (exp_f == 8'h00) begin	// Zero or subnormal
			man_n = {1'b0, frac} << lz;
			exp_n = EXP_W'(1 - EXP_BIAS - int'(lz));
		end else begin
			man_n = {1'b1, frac};
			exp_n = EXP_W'(int'(exp_f) - EXP_BIAS);
		end
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset)
			valid_out <= 1'b0;
		else if (flush)
			valid_out <= 1'b0;
		else if (ready_out)
			valid_out <= valid_in;
	end

	always_ff @(posedge clk) begin
		if (valid_in && ready_out) begin
			man_a  <= man_n;
			exp_a  <= exp_n;
			sgn_a  <= operand[31];
			zero_a <= (exp_f == 8'h00) && (frac == '0);
			inf_a  <= (exp_f == EXP_ALL_ONES) && (frac == '0);
			snan_a <= (exp_f == EXP_ALL_ONES) && (frac != '0) && !frac[FRAC_W-1];
			qnan_a <= (exp_f == EXP_ALL_ONES) && frac[FRAC_W-1];
			rm_out <= rm_in;
		end
	end

endmodule

//--- float_sqrt.sv
`timescale 1ns/10ps

module float_sqrt (
	input	logic								clk,
	input	logic								reset,
	input	logic								flush,

	input	logic								valid_in,
	output	logic								ready_out,
	output	logic								valid_out,
	input	logic								ready_in,

	input	fpu_pkg::rm_t						rm,

	input	logic	[float_pkg::MAN_W-1:0]		man_a,
	input	logic	signed [float_pkg::EXP_W-1:0]	exp_a,
	input	logic								sgn_a,
	input	logic								zero_a,
	input	logic								inf_a,
	input	logic								snan_a,
	input	logic								qnan_a,

	output	logic	[float_pkg::MAN_W-1:0]		man_y,
	output	logic	[float_pkg::EXP_W-1:0]		exp_y,
	output	logic								sgn_y,
	output	logic								round_bit,
	output	logic								sticky_bit,
	output	logic								skip_round,
	output	logic								iv,
	output	fpu_pkg::rm_t						rm_out
);
	import float_pkg::*;

	typedef enum logic {IDLE, CALC} state_t;

	state_t			state;

	logic	[25:0]	rad_buf;	// Radicand, consumed two bits at a time
	logic	[25:0]	res_buf;	// Root bits developed so far
	logic	[27:0]	rem_buf;	// Partial remainder

	logic	[27:0]	shf1;
	logic	[27:0]	try1;
	logic	[27:0]	rem1;
	logic	[27:0]	shf2;
	logic	[27:0]	try2;
	logic	[27:0]	rem2;
	logic	[1:0]	s;

	logic			take;
	logic			special;

	assign ready_out = ready_in && (state == IDLE);
	assign take      = valid_in && ready_out;
	assign special   = zero_a || sgn_a || snan_a || qnan_a || inf_a;

	assign man_y      = res_buf[25:2];
	assign round_bit  = res_buf[1];
	assign sticky_bit = |rem_buf || res_buf[0];

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			state     <= IDLE;
			valid_out <= 1'b0;
		end else if (flush) begin
			state     <= IDLE;
			valid_out <= 1'b0;
		end else if (take) begin
			valid_out <= special;	// Specials bypass the loop
			state     <= special ? IDLE : CALC;
		end else if (state == CALC) begin
			// Leading root bit set, so this is the last pair
			if (res_buf[23]) begin
				valid_out <= 1'b1;
				state     <= IDLE;
			end
		end else if (valid_out && ready_in) begin
			valid_out <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			rm_out  <= rm;
			rem_buf <= 28'd0;
			rad_buf <= 26'd0;
			sgn_y   <= 1'b0;
			if (zero_a) begin	// Signed zero passes through
				res_buf    <= 26'd0;
				exp_y      <= '0;
				sgn_y      <= sgn_a;
				skip_round <= 1'b1;
				iv         <= 1'b0;
			end else if (sgn_a || snan_a || qnan_a) begin
				res_buf    <= {1'b1, QNAN_BITS[22:0], 2'b00};
				exp_y      <= {2'b00, QNAN_BITS[30:23]};
				skip_round <= 1'b1;
				iv         <= 1'b1;
			end else if (inf_a) begin	// +inf stays +inf
				res_buf    <= {1'b1, POS_INF_BITS[22:0], 2'b00};
				exp_y      <= {2'b00, POS_INF_BITS[30:23]};
				skip_round <= 1'b1;
				iv         <= 1'b0;
			end else begin
				// Odd exponent folds one factor of two into the radicand
				rad_buf    <= {1'b0, man_a, 1'b0} << exp_a[0];
				res_buf    <= 26'd0;
				exp_y      <= exp_a >>> 1;
				skip_round <= 1'b0;
				iv         <= 1'b0;
			end
		end else if (state == CALC) begin
			rad_buf <= rad_buf << 4;
			res_buf <= {res_buf[23:0], s};
			rem_buf <= rem2;
		end
	end

	// Two restoring steps per cycle
	always_comb begin
		shf1 = {rem_buf[25:0], rad_buf[25:24]};
		try1 = shf1 - {res_buf[25:0], 2'b01};
		s[1] = !try1[27];
		rem1 = s[1] ? try1 : shf1;

		shf2 = {rem1[25:0], rad_buf[23:22]};
		try2 = shf2 - {res_buf[24:0], s[1], 2'b01};
		s[0] = !try2[27];
		rem2 = s[0] ? try2 : shf2;
	end

endmodule

//--- float_round.sv
`timescale 1ns/10ps

module float_round (
	input	logic							clk,
	input	logic							reset,
	input	logic							flush,

	input	logic							valid_in,
	output	logic							ready_out,

	input	logic	[float_pkg::MAN_W-1:0]	man_y,
	input	logic	[float_pkg::EXP_W-1:0]	exp_y,
	input	logic							sgn_y,
	input	logic							round_bit,
	input	logic							sticky_bit,
	input	logic							skip_round,
	input	logic							iv,
	input	fpu_pkg::rm_t					rm,

	output	logic							valid_out,
	input	logic							ready_in,
	output	logic	[31:0]					result,
	output	logic	[1:0]					flags
);
	import fpu_pkg::*;
	import float_pkg::*;

	logic					inc;
	logic	[MAN_W:0]		sum;
	logic	[FRAC_W-1:0]	man_r;
	logic	[7:0]			exp_b;
	logic	[31:0]			result_n;
	logic	[1:0]			flags_n;

	assign ready_out = !valid_out || ready_in;

	always_comb begin
		case (rm)
			RM_RTZ, RM_RDN:	inc = 1'b0;	// Root is positive, down truncates
			RM_RUP:			inc = round_bit || sticky_bit;
			RM_RMM:			inc = round_bit;
			default:		inc = round_bit && (sticky_bit || man_y[0]);
		endcase

		sum   = {1'b0, man_y} + (MAN_W + 1)'(inc);
		man_r = sum[MAN_W] ? sum[MAN_W-1:1] : sum[FRAC_W-1:0];
		exp_b = 8'($signed(exp_y) + EXP_BIAS + int'(sum[MAN_W]));	// Carry bumps the exponent

		if (skip_round)
			result_n = {sgn_y, exp_y[7:0], man_y[FRAC_W-1:0]};
		else
			result_n = {sgn_y, exp_b, man_r};

		flags_n = 2'b00;
		flags_n[FLAG_NV] = iv;
		flags_n[FLAG_NX] = !skip_round && (round_bit || sticky_bit);
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset)
			valid_out <= 1'b0;
		else if (flush)
			valid_out <= 1'b0;
		else if (ready_out)
			valid_out <= valid_in;
	end

	always_ff @(posedge clk) begin
		if (valid_in && ready_out) begin
			result <= result_n;
			flags  <= flags_n;
		end
	end

endmodule

//--- fpu_sqrt_top.sv
`timescale 1ns/10ps

module fpu_sqrt_top #(
	parameter int ADDR_W = 4
) (
	input	logic					clk,
	input	logic					reset,

	input	logic	[ADDR_W-1:0]	awaddr,
	input	logic					awvalid,
	output	logic					awready,
	input	logic	[31:0]			wdata,
	input	logic	[3:0]			wstrb,
	input	logic					wvalid,
	output	logic					wready,
	output	logic	[1:0]			bresp,
	output	logic					bvalid,
	input	logic					bready,
	input	logic	[ADDR_W-1:0]	araddr,
	input	logic					arvalid,
	output	logic					arready,
	output	logic	[31:0]			rdata,
	output	logic	[1:0]			rresp,
	output	logic					rvalid,
	input	logic					rready
);

	logic					start_valid;
	logic					start_ready;
	logic	[31:0]			operand;
	fpu_pkg::rm_t			rm;
	logic					flush;
	logic					res_valid;
	logic	[31:0]			result;
	logic	[1:0]			flags;

	logic					up_valid;
	logic					up_ready;
	logic	[23:0]			man_a;
	logic	signed [9:0]	exp_a;
	logic					sgn_a;
	logic					zero_a;
	logic					inf_a;
	logic					snan_a;
	logic					qnan_a;
	fpu_pkg::rm_t			up_rm;

	logic					sq_valid;
	logic					sq_ready;
	logic	[23:0]			man_y;
	logic	[9:0]			exp_y;
	logic					sgn_y;
	logic					round_bit;
	logic					sticky_bit;
	logic					skip_round;
	logic					iv;
	fpu_pkg::rm_t			sq_rm;

	fpu_axil_regs #(
		.ADDR_W		(ADDR_W)
	) u_regs (
		.clk		(clk),
		.reset		(reset),
		.awaddr		(awaddr),
		.awvalid	(awvalid),
		.awready	(awready),
		.wdata		(wdata),
		.wstrb		(wstrb),
		.wvalid		(wvalid),
		.wready		(wready),
		.bresp		(bresp),
		.bvalid		(bvalid),
		.bready		(bready),
		.araddr		(araddr),
		.arvalid	(arvalid),
		.arready	(arready),
		.rdata		(rdata),
		.rresp		(rresp),
		.rvalid		(rvalid),
		.rready		(rready),
		.start_valid	(start_valid),
		.start_ready	(start_ready),
		.operand	(operand),
		.rm			(rm),
		.flush		(flush),
		.res_valid	(res_valid),
		.result		(result),
		.flags		(flags)
	);

	float_unpack u_unpack (
		.clk		(clk),
		.reset		(reset),
		.flush		(flush),
		.valid_in	(start_valid),
		.ready_out	(start_ready),
		.operand	(operand),
		.rm_in		(rm),
		.valid_out	(up_valid),
		.ready_in	(up_ready),
		.man_a		(man_a),
		.exp_a		(exp_a),
		.sgn_a		(sgn_a),
		.zero_a		(zero_a),
		.inf_a		(inf_a),
		.snan_a		(snan_a),
		.qnan_a		(qnan_a),
		.rm_out		(up_rm)
	);

	float_sqrt u_sqrt (
		.clk		(clk),
		.reset		(reset),
		.flush		(flush),
		.valid_in	(up_valid),
		.ready_out	(up_ready),
		.valid_out	(sq_valid),
		.ready_in	(sq_ready),
		.rm			(up_rm),
		.man_a		(man_a),
		.exp_a		(exp_a),
		.sgn_a		(sgn_a),
		.zero_a		(zero_a),
		.inf_a		(inf_a),
		.snan_a		(snan_a),
		.qnan_a		(qnan_a),
		.man_y		(man_y),
		.exp_y		(exp_y),
		.sgn_y		(sgn_y),
		.round_bit	(round_bit),
		.sticky_bit	(sticky_bit),
		.skip_round	(skip_round),
		.iv			(iv),
		.rm_out		(sq_rm)
	);

	// Register block always takes the result
	float_round u_round (
		.clk		(clk),
		.reset		(reset),
		.flush		(flush),
		.valid_in	(sq_valid),
		.ready_out	(sq_ready),
		.man_y		(man_y),
		.exp_y		(exp_y),
		.sgn_y		(sgn_y),
		.round_bit	(round_bit),
		.sticky_bit	(sticky_bit),
		.skip_round	(skip_round),
		.iv			(iv),
		.rm			(sq_rm),
		.valid_out	(res_valid),
		.ready_in	(1'b1),
		.result		(result),
		.flags		(flags)
	);

endmodule

//--- fpu_sqrt_properties.sv
`timescale 1ns/10ps

module fpu_sqrt_properties (
	input	logic			clk,
	input	logic			reset,
	input	logic			awvalid,
	input	logic			awready,
	input	logic			wvalid,
	input	logic			wready,
	input	logic	[1:0]	bresp,
	input	logic			bvalid,
	input	logic			bready,
	input	logic			arvalid,
	input	logic			arready,
	input	logic	[1:0]	rresp,
	input	logic			rvalid,
	input	logic			rready
);

	// Valid holds until the matching ready
	aw_hold: assert property (@(posedge clk) disable iff (reset)
		awvalid && !awready |=> awvalid) else $error("awvalid dropped before awready");
	w_hold: assert property (@(posedge clk) disable iff (reset)
		wvalid && !wready |=> wvalid) else $error("wvalid dropped before wready");
	ar_hold: assert property (@(posedge clk) disable iff (reset)
		arvalid && !arready |=> arvalid) else $error("arvalid dropped before arready");
	b_hold: assert property (@(posedge clk) disable iff (reset)
		bvalid && !bready |=> bvalid) else $error("bvalid dropped before bready");
	r_hold: assert property (@(posedge clk) disable iff (reset)
		rvalid && !rready |=> rvalid) else $error("rvalid dropped before rready");

	b_okay: assert property (@(posedge clk) disable iff (reset)
		bvalid |-> bresp == 2'b00) else $error("write response not OKAY");
	r_okay: assert property (@(posedge clk) disable iff (reset)
		rvalid |-> rresp == 2'b00) else $error("read response not OKAY");

	// A response needs an accepted request just before it
	b_req: assert property (@(posedge clk) disable iff (reset)
		$rose(bvalid) |-> $past(awvalid && awready)) else $error("bvalid without a write");
	r_req: assert property (@(posedge clk) disable iff (reset)
		$rose(rvalid) |-> $past(arvalid && arready)) else $error("rvalid without a read");

endmodule

//--- tb_fpu_sqrt.sv
`timescale 1ns/10ps

module tb_fpu_sqrt;
	import fpu_pkg::*;

	localparam int N_DIR   = 26;
	localparam int N_RAND  = 40;
	localparam int N_TESTS = N_DIR + N_RAND + 2;
	localparam int LIMIT   = N_TESTS * 40 + 200;

	// Operand, rounding mode, expected result, expected flags {NX, NV}
	localparam logic [68:0] CASES [N_DIR] = '{
		{32'h4080_0000, 3'd0, 32'h4000_0000, 2'b00},	// 4.0
		{32'h3e80_0000, 3'd0, 32'h3f00_0000, 2'b00},	// 0.25
		{32'h0080_0000, 3'd0, 32'h2000_0000, 2'b00},	// 2^-126
		{32'h4110_0000, 3'd0, 32'h4040_0000, 2'b00},	// 9.0
		{32'h0000_0000, 3'd0, 32'h0000_0000, 2'b00},
		{32'h8000_0000, 3'd0, 32'h8000_0000, 2'b00},
		{32'h7f80_0000, 3'd0, 32'h7f80_0000, 2'b00},
		{32'hbf80_0000, 3'd0, 32'h7fc0_0000, 2'b01},	// -1.0
		{32'h7fc0_0000, 3'd0, 32'h7fc0_0000, 2'b01},
		{32'h7f80_0001, 3'd0, 32'h7fc0_0000, 2'b01},	// Signalling NaN
		{32'h4000_0000, 3'd0, 32'h3fb5_04f3, 2'b10},	// sqrt(2), round bit clear
		{32'h4000_0000, 3'd1, 32'h3fb5_04f3, 2'b10},
		{32'h4000_0000, 3'd2, 32'h3fb5_04f3, 2'b10},
		{32'h4000_0000, 3'd3, 32'h3fb5_04f4, 2'b10},
		{32'h4000_0000, 3'd4, 32'h3fb5_04f3, 2'b10},
		{32'h4040_0000, 3'd0, 32'h3fdd_b3d7, 2'b10},	// sqrt(3)
		{32'h4040_0000, 3'd1, 32'h3fdd_b3d7, 2'b10},
		{32'h4040_0000, 3'd2, 32'h3fdd_b3d7, 2'b10},
		{32'h4040_0000, 3'd3, 32'h3fdd_b3d8, 2'b10},
		{32'h4040_0000, 3'd4, 32'h3fdd_b3d7, 2'b10},
		{32'h40a0_0000, 3'd1, 32'h400f_1bbc, 2'b10},	// sqrt(5), round bit set
		{32'h40a0_0000, 3'd2, 32'h400f_1bbc, 2'b10},
		{32'h40a0_0000, 3'd4, 32'h400f_1bbd, 2'b10},
		{32'h0000_0002, 3'd0, 32'h1a80_0000, 2'b00},	// Subnormal 2^-148
		{32'h0000_0001, 3'd0, 32'h1a35_04f3, 2'b10},
		{32'h0040_0000, 3'd0, 32'h1fb5_04f3, 2'b10}
	};

	logic			clk;
	logic			reset;
	logic	[3:0]	awaddr;
	logic			awvalid;
	logic	[31:0]	wdata;
	logic	[3:0]	wstrb;
	logic			wvalid;
	logic			bready;
	logic	[3:0]	araddr;
	logic			arvalid;
	logic			rready;
	logic			awready;
	logic			wready;
	logic	[1:0]	bresp;
	logic			bvalid;
	logic			arready;
	logic	[31:0]	rdata;
	logic	[1:0]	rresp;
	logic			rvalid;

	int				cycles;
	int				errors;
	int				passes;
	integer			seed;

	fpu_sqrt_top #(.ADDR_W(4)) u_dut (.*);

	bind fpu_sqrt_top fpu_sqrt_properties u_props (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", LIMIT);
			$display("*** FAILED ***");
			$finish;
		end
	end

	task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
		@(negedge clk);
		awaddr  = addr[3:0];
		wdata   = data;
		wstrb   = 4'hf;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		do @(negedge clk); while (!awready);
		@(negedge clk);	// Hold through the accepting edge
		awvalid = 1'b0;
		wvalid  = 1'b0;
		while (!bvalid)
			@(negedge clk);
		bready = 1'b1;
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
		@(negedge clk);
		araddr  = addr[3:0];
		arvalid = 1'b1;
		do @(negedge clk); while (!arready);
		@(negedge clk);
		arvalid = 1'b0;
		while (!rvalid)
			@(negedge clk);
		data   = rdata;
		rready = 1'b1;
		@(negedge clk);
		rready = 0;
	endtask

	task automatic start_sqrt(input logic [31:0] op, input logic [2:0] mode);
		axi_write(REG_OPERAND, op);
		axi_write(REG_CTRL, {27'd0, mode, 1'b0, 1'b1});
	endtask

	task automatic run_sqrt(input logic [31:0] op, input logic [2:0] mode,
			output logic [31:0] res, output logic [1:0] flg);
		logic [31:0] stat;
		start_sqrt(op, mode);
		do axi_read(REG_STATUS, stat); while (!stat[STAT_DONE]);
		flg = stat[STAT_FLAGS_LSB +: 2];
		axi_read(REG_RESULT, res);
	endtask

	task automatic check_result(input int num, input logic [31:0] op, input logic [2:0] mode,
			input logic [31:0] res, input logic [1:0] flg,
			input logic [31:0] exp_res, input logic [1:0] exp_flg);
		if (res !== exp_res || flg !== exp_flg) begin
			$display("Error at %0t: test %0d sqrt(%h) rm %0d = %h/%b, expected %h/%b",
				$time, num, op, mode, res, flg, exp_res, exp_flg);
			errors++;
		end else begin
			$display("Test %0d sqrt(%h) rm %0d = %h flags %b ok", num, op, mode, res, flg);
			passes++;
		end
	endtask

	// Double-precision root, then rounded to single with ties to even
	function automatic logic [31:0] sqrt_model(input logic [31:0] op, output logic inexact);
		real			x;
		logic	[63:0]	db;
		logic			inc;
		x   = $bitstoreal({1'b0, 11'(int'(op[30:23]) - 127 + 1023), op[22:0], 29'd0});
		db  = $realtobits($sqrt(x));
		inc = db[28] && ((|db[27:0]) || db[29]);
		inexact = |db[28:0];	// Bits below the single-precision LSB
		return {1'b0, 8'(int'(db[62:52]) - 1023 + 127), db[51:29]} + 32'(inc);
	endfunction

	initial begin
		logic	[31:0]	op;
		logic	[31:0]	res;
		logic	[31:0]	stat;
		logic	[1:0]	flg;
		logic	[31:0]	exp_res;
		logic			nx;
		cycles  = 0;
		errors  = 0;
		passes  = 0;
		seed    = 32'he16a_bfda;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		reset   = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		for (int i = 0; i < N_DIR; i++) begin
			run_sqrt(CASES[i][68:37], CASES[i][36:34], res, flg);
			check_result(i, CASES[i][68:37], CASES[i][36:34], res, flg,
				CASES[i][33:2], CASES[i][1:0]);
		end

		// Flush mid calculation
		start_sqrt(32'h4000_0000, 3'd0);
		axi_write(REG_CTRL, 32'd1 << CTRL_FLUSH);
		axi_read(REG_STATUS, stat);
		repeat (40) @(negedge clk);	// Longer than the full latency
		axi_read(REG_STATUS, res);
		if (stat[1:0] != 2'b00 || res[1:0] != 2'b00) begin
			$display("Error at %0t: busy or done set after flush, status %h then %h",
				$time, stat, res);
			errors++;
		end else begin
			$display("Test %0d flush leaves status idle ok", N_DIR);
			passes++;
		end

		// Second start while busy must not replace the first
		start_sqrt(32'h4080_0000, 3'd0);
		start_sqrt(32'h4110_0000, 3'd0);
		do axi_read(REG_STATUS, stat); while (!stat[STAT_DONE]);
		axi_read(REG_RESULT, res);
		check_result(N_DIR + 1, 32'h4080_0000, 3'd0, res, stat[3:2], 32'h4000_0000, 2'b00);

		for (int i = 0; i < N_RAND; i++) begin
			op = {1'b0, 8'(1 + ($unsigned($random(seed)) % 254)), 23'($random(seed))};
			run_sqrt(op, 3'd0, res, flg);
			exp_res = sqrt_model(op, nx);
			check_result(N_DIR + 2 + i, op, 3'd0, res, flg, exp_res, {nx, 1'b0});
		end

		$display("Tests run %0d, passed %0d, failed %0d", N_TESTS, passes, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

//--- list.f
fpu_pkg.sv
float_pkg.sv
fpu_axil_regs.sv
float_unpack.sv
float_sqrt.sv
float_round.sv
fpu_sqrt_top.sv
fpu_sqrt_properties.sv
tb_fpu_sqrt.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_fpu_sqrt
RTL_TOP   ?= fpu_sqrt_top
FLIST     ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q -F '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
